//--- exec_alu.sv
// ALU for the execute stage
// Adder with optional operand inversion, xor, and-not and the shifter,
// plus zero, sign, overflow and carry flags
`timescale 1ns/1ps
`include "exec_defs.svh"

module exec_alu (
    input  logic [`EXEC_DATA_W-1:0] inA,
    input  logic [`EXEC_DATA_W-1:0] inB,
    input  exec_pkg::aluOp          op,
    input  logic                    invA,
    input  logic                    invB,
    input  logic                    cIn,
    input  logic                    ovfEn,
    output logic [`EXEC_DATA_W-1:0] aluOut,
    output logic                    zero,
    output logic                    ltz,
    output logic                    ovf,
    output logic                    cOut
);
    import exec_pkg::*;

    logic [`EXEC_DATA_W-1:0] opA;
    logic [`EXEC_DATA_W-1:0] opB;
    logic [`EXEC_DATA_W-1:0] sum;
    logic [`EXEC_DATA_W-1:0] shOut;
    logic                    carry;
    logic                    sumOvf;

    assign opA = invA ? ~inA : inA;
    assign opB = invB ? ~inB : inB;

    // Subtract is ~a + b + 1, so the adder serves both
    assign {carry, sum} = {1'b0, opA} + {1'b0, opB} + {{`EXEC_DATA_W{1'b0}}, cIn};

    // Signed overflow when like-signed inputs give an unlike-signed sum
    assign sumOvf = (opA[`EXEC_DATA_W-1] == opB[`EXEC_DATA_W-1]) &&
                    (sum[`EXEC_DATA_W-1] != opA[`EXEC_DATA_W-1]);

    // Shift amount comes from the low bits of the second operand
    exec_shifter shifter0 (
        .din   (inA),
        .shamt (inB[`EXEC_SHAMT_W-1:0]),
        .op    (op),
        .dout  (shOut)
    );

    always_comb begin
        case (op)
            aluAdd, aluSub: aluOut = sum;
            aluXor:         aluOut = opA ^ opB;
            // invB is set for and-not, so this is a & ~b
            aluAndn:        aluOut = opA & opB;
            default:        aluOut = shOut;
        endcase
    end

    assign zero = (aluOut == '0);
    assign ltz  = aluOut[`EXEC_DATA_W-1];
    assign ovf  = ovfEn && sumOvf;
    assign cOut = carry;

endmodule

//--- exec_decode.sv
// Execute stage decoder
// Maps the opcode and function field to ALU controls, an extended
// immediate and the kind of result the stage has to select
`timescale 1ns/1ps
`include "exec_defs.svh"

module exec_decode (
    input  exec_pkg::instrWord      instr,
    output exec_pkg::aluOp          op,
    output logic                    useImm,
    output logic                    invA,
    output logic                    invB,
    output logic                    cIn,
    output logic                    ovfEn,
    output logic [`EXEC_DATA_W-1:0] immVal,
    output exec_pkg::resKind        kind
);
    import exec_pkg::*;

    logic [`EXEC_DATA_W-1:0] imm5Sext, imm5Zext, imm8Sext, imm8Zext;

    assign imm5Sext = {{(`EXEC_DATA_W-5){instr.iFmt.imm5[4]}}, instr.iFmt.imm5};
    assign imm5Zext = {{(`EXEC_DATA_W-5){1'b0}}, instr.iFmt.imm5};
    assign imm8Sext = {{(`EXEC_DATA_W-8){instr.lFmt.imm8[7]}}, instr.lFmt.imm8};
    assign imm8Zext = {{(`EXEC_DATA_W-8){1'b0}}, instr.lFmt.imm8};

    always_comb begin
        // Default is rs plus zero, which covers branches and unlisted opcodes
        op     = aluAdd;
        useImm = 1'b1;
        invA   = 1'b0;
        invB   = 1'b0;
        cIn    = 1'b0;
        ovfEn  = 1'b0;
        immVal = '0;
        kind   = kindAlu;
        case (instr.rFmt.opcode)
            `OP_ADDI: begin
                immVal = imm5Sext;
                ovfEn  = 1'b1;
            end
            // Immediate minus rs
            `OP_SUBI: begin
                op     = aluSub;
                immVal = imm5Sext;
                invA   = 1'b1;
                cIn    = 1'b1;
                ovfEn  = 1'b1;
            end
            `OP_XORI: begin
                op     = aluXor;
                immVal = imm5Zext;
            end
            `OP_ANDNI: begin
                op     = aluAndn;
                immVal = imm5Zext;
                invB   = 1'b1;
            end
            `OP_ROLI: begin
                op     = aluRol;
                immVal = imm5Zext;
            end
            `OP_SLLI: begin
                op     = aluSll;
                immVal = imm5Zext;
            end
            `OP_RORI: begin
                op     = aluRor;
                immVal = imm5Zext;
            end
            `OP_SRLI: begin
                op     = aluSrl;
                immVal = imm5Zext;
            end
            `OP_ST, `OP_LD, `OP_STU: immVal = imm5Sext;
            `OP_BTR: kind = kindBtr;
            `OP_ALUR: begin
                useImm = 1'b0;
                case (instr.rFmt.func)
                    2'b00: ovfEn = 1'b1;
                    2'b01: begin
                        op    = aluSub;
                        invA  = 1'b1;
                        cIn   = 1'b1;
                        ovfEn = 1'b1;
                    end
                    2'b10: op = aluXor;
                    default: begin
                        op   = aluAndn;
                        invB = 1'b1;
                    end
                endcase
            end
            `OP_SHFR: begin
                useImm = 1'b0;
                case (instr.rFmt.func)
                    2'b00:   op = aluRol;
                    2'b01:   op = aluSll;
                    2'b10:   op = aluRor;
                    default: op = aluSrl;
                endcase
            end
            // Compares all run rt minus rs
            `OP_SEQ, `OP_SLT, `OP_SLE: begin
                op     = aluSub;
                useImm = 1'b0;
                invA   = 1'b1;
                cIn    = 1'b1;
                kind   = (instr.rFmt.opcode == `OP_SEQ) ? kindSeq :
                         (instr.rFmt.opcode == `OP_SLT) ? kindSlt : kindSle;
            end
            `OP_SCO: begin
                useImm = 1'b0;
                kind   = kindSco;
            end
            `OP_LBI: begin
                immVal = imm8Sext;
                kind   = kindLbi;
            end
            `OP_SLBI: begin
                immVal = imm8Zext;
                kind   = kindSlbi;
            end
            default: ;
        endcase
    end

endmodule

//--- exec_defs.svh
// Execute stage constants
// Data and shift-amount widths plus the 5-bit opcode encodings
`ifndef EXEC_DEFS_SVH
`define EXEC_DEFS_SVH

`define EXEC_DATA_W  16
`define EXEC_SHAMT_W 4

// Immediate arithmetic and logic
`define OP_ADDI  5'b01000
`define OP_SUBI  5'b01001
`define OP_XORI  5'b01010
`define OP_ANDNI 5'b01011

// Immediate shifts and rotates
`define OP_ROLI  5'b10100
`define OP_SLLI  5'b10101
`define OP_RORI  5'b10110
`define OP_SRLI  5'b10111

// Memory address forms
`define OP_ST    5'b10000
`define OP_LD    5'b10001
`define OP_STU   5'b10011

`define OP_BTR   5'b11001
`define OP_ALUR  5'b11011
`define OP_SHFR  5'b11010

// Set instructions share the 111 prefix
`define OP_SEQ   5'b11100
`define OP_SLT   5'b11101
`define OP_SLE   5'b11110
`define OP_SCO   5'b11111

// Branches share the 011 prefix
`define OP_BEQZ  5'b01100
`define OP_BNEZ  5'b01101
`define OP_BLTZ  5'b01110
`define OP_BGEZ  5'b01111

`define OP_LBI   5'b11000
`define OP_SLBI  5'b10010

`endif

//--- exec_pkg.sv
// Execute stage types
// Instruction word views and the control encodings passed between blocks
package exec_pkg;

    // Register-register format
    typedef struct packed {
        logic [4:0] opcode;
        logic [2:0] rs;
        logic [2:0] rt;
        logic [2:0] rd;
        logic [1:0] func;
    } rFmtFields;

    // Short immediate format
    typedef struct packed {
        logic [4:0] opcode;
        logic [2:0] rs;
        logic [2:0] rd;
        logic [4:0] imm5;
    } iFmtFields;

    // Long immediate format, used by LBI and SLBI
    typedef struct packed {
        logic [4:0] opcode;
        logic [2:0] rs;
        logic [7:0] imm8;
    } lFmtFields;

    // One 16-bit word, read through whichever format the opcode implies
    typedef union packed {
        rFmtFields rFmt;
        iFmtFields iFmt;
        lFmtFields lFmt;
    } instrWord;

    typedef enum logic [2:0] {
        aluAdd  = 3'd0,
        aluSub  = 3'd1,
        aluXor  = 3'd2,
        aluAndn = 3'd3,
        aluRol  = 3'd4,
        aluSll  = 3'd5,
        aluRor  = 3'd6,
        aluSrl  = 3'd7
    } aluOp;

    // Operand source, ordered as the pipeline's forwarding mux
    typedef enum logic [1:0] {
        fwdNone     = 2'd0,
        fwdMemWbAlu = 2'd1,
        fwdExMemAlu = 2'd2,
        fwdMemWbMem = 2'd3
    } fwdSel;

    typedef enum logic [2:0] {
        kindAlu  = 3'd0,
        kindSeq  = 3'd1,
        kindSlt  = 3'd2,
        kindSle  = 3'd3,
        kindSco  = 3'd4,
        kindBtr  = 3'd5,
        kindLbi  = 3'd6,
        kindSlbi = 3'd7
    } resKind;

endpackage

//--- exec_shifter.sv
// Barrel shifter
// Rotate and shift in both directions on one left-moving log barrel,
// with right moves done by reversing the word on the way in and out
`timescale 1ns/1ps
`include "exec_defs.svh"

module exec_shifter (
    input  logic [`EXEC_DATA_W-1:0]  din,
    input  logic [`EXEC_SHAMT_W-1:0] shamt,
    input  exec_pkg::aluOp           op,
    output logic [`EXEC_DATA_W-1:0]  dout
);
    import exec_pkg::*;

    logic                    isRight;
    logic                    isRot;
    logic [`EXEC_DATA_W-1:0] dinRev;
    logic [`EXEC_DATA_W-1:0] outRev;
    logic [`EXEC_DATA_W-1:0] level [0:`EXEC_SHAMT_W];

    assign isRight = (op == aluRor) || (op == aluSrl);
    assign isRot   = (op == aluRol) || (op == aluRor);

    assign dinRev   = {<<{din}};
    assign level[0] = isRight ? dinRev : din;

    // Level i moves by 2**i when its shamt bit is set
    for (genvar i = 0; i < `EXEC_SHAMT_W; i++) begin : gLevel
        localparam int Amt = 1 << i;
        logic [`EXEC_DATA_W-1:0] rotVal;
        logic [`EXEC_DATA_W-1:0] shlVal;

        assign rotVal = {level[i][`EXEC_DATA_W-Amt-1:0], level[i][`EXEC_DATA_W-1 -: Amt]};
        assign shlVal = {level[i][`EXEC_DATA_W-Amt-1:0], {Amt{1'b0}}};

        assign level[i+1] = !shamt[i] ? level[i] :
                            isRot     ? rotVal   : shlVal;
    end

    assign outRev = {<<{level[`EXEC_SHAMT_W]}};
    assign dout   = isRight ? outRev : level[`EXEC_SHAMT_W];

endmodule

//--- exec_stage.sv
// Execute stage datapath
// Operand forwarding, LBI/SLBI operand shaping, the ALU, set values
// and bit reverse, with the final result picked by result kind
`timescale 1ns/1ps
`include "exec_defs.svh"

module exec_stage (
    input  logic [`EXEC_DATA_W-1:0] rsData,
    input  logic [`EXEC_DATA_W-1:0] rtData,
    input  logic [`EXEC_DATA_W-1:0] immVal,
    input  logic [`EXEC_DATA_W-1:0] aluResExMem,
    input  logic [`EXEC_DATA_W-1:0] aluResMemWb,
    input  logic [`EXEC_DATA_W-1:0] memDataMemWb,
    input  exec_pkg::fwdSel         fwdSelA,
    input  exec_pkg::fwdSel         fwdSelB,
    input  exec_pkg::aluOp          op,
    input  logic                    useImm,
    input  logic                    invA,
    input  logic                    invB,
    input  logic                    cIn,
    input  logic                    ovfEn,
    input  exec_pkg::resKind        kind,
    output logic [`EXEC_DATA_W-1:0] result,
    output logic                    zero,
    output logic                    ltz,
    output logic                    err
);
    import exec_pkg::*;

    logic [`EXEC_DATA_W-1:0] rsFwd, rtFwd, inA, inB, aluOut, btrVal;
    logic                    aluZero, aluLtz, aluOvf, cOut;
    logic                    diffOvf, diffNeg, setVal;

    function automatic logic [`EXEC_DATA_W-1:0] pickFwd(
        input fwdSel                   sel,
        input logic [`EXEC_DATA_W-1:0] regVal,
        input logic [`EXEC_DATA_W-1:0] exMemAlu,
        input logic [`EXEC_DATA_W-1:0] memWbAlu,
        input logic [`EXEC_DATA_W-1:0] memWbMem
    );
        case (sel)
            fwdMemWbAlu: return memWbAlu;
            fwdExMemAlu: return exMemAlu;
            fwdMemWbMem: return memWbMem;
            default:     return regVal;
        endcase
    endfunction

    assign rsFwd = pickFwd(fwdSelA, rsData, aluResExMem, aluResMemWb, memDataMemWb);
    assign rtFwd = pickFwd(fwdSelB, rtData, aluResExMem, aluResMemWb, memDataMemWb);

    // LBI adds its immediate to zero, SLBI adds a zero-extended byte to rs << 8
    assign inA = (kind == kindLbi)  ? '0 :
                 (kind == kindSlbi) ? {rsFwd[`EXEC_DATA_W-9:0], 8'h00} : rsFwd;
    assign inB = useImm ? immVal : rtFwd;

    exec_alu alu0 (
        .inA    (inA),
        .inB    (inB),
        .op     (op),
        .invA   (invA),
        .invB   (invB),
        .cIn    (cIn),
        .ovfEn  (ovfEn),
        .aluOut (aluOut),
        .zero   (aluZero),
        .ltz    (aluLtz),
        .ovf    (aluOvf),
        .cOut   (cOut)
    );

    // Overflow of rt - rs, so the true sign survives a wrapped difference
    assign diffOvf = (inB[`EXEC_DATA_W-1] ^ inA[`EXEC_DATA_W-1]) &&
                     (aluOut[`EXEC_DATA_W-1] ^ inB[`EXEC_DATA_W-1]);
    assign diffNeg = aluLtz ^ diffOvf;

    always_comb begin
        case (kind)
            kindSeq: setVal = aluZero;
            kindSlt: setVal = !diffNeg && !aluZero;
            kindSle: setVal = !diffNeg;
            default: setVal = cOut;
        endcase
    end

    assign btrVal = {<<{rsFwd}};

    always_comb begin
        case (kind)
            kindSeq, kindSlt, kindSle, kindSco: result = {{(`EXEC_DATA_W-1){1'b0}}, setVal};
            kindBtr: result = btrVal;
            default: result = aluOut;
        endcase
    end

    assign zero = aluZero;
    assign ltz  = aluLtz;
    assign err  = aluOvf;

endmodule

//--- exec_top.sv
// Execute stage top level
// Decodes at the input, registers controls and operands, runs the stage
// and registers its outputs, for a fixed latency of two clocks
`timescale 1ns/1ps
`include "exec_defs.svh"

module exec_top (
    input  logic                    clk,
    input  logic                    rstN,
    input  logic                    inValid,
    input  exec_pkg::instrWord      instr,
    input  logic [`EXEC_DATA_W-1:0] rsData,
    input  logic [`EXEC_DATA_W-1:0] rtData,
    input  logic [`EXEC_DATA_W-1:0] aluResExMem,
    input  logic [`EXEC_DATA_W-1:0] aluResMemWb,
    input  logic [`EXEC_DATA_W-1:0] memDataMemWb,
    input  exec_pkg::fwdSel         fwdSelA,
    input  exec_pkg::fwdSel         fwdSelB,
    output logic                    outValid,
    output logic [`EXEC_DATA_W-1:0] result,
    output logic                    zero,
    output logic                    ltz,
    output logic                    err
);
    import exec_pkg::*;

    // Decoder outputs
    aluOp                    decOp;
    logic                    decUseImm, decInvA, decInvB, decCIn, decOvfEn;
    logic [`EXEC_DATA_W-1:0] decImm;
    resKind                  decKind;

    // Input register
    logic                    validQ;
    aluOp                    opQ;
    logic                    useImmQ, invAQ, invBQ, cInQ, ovfEnQ;
    logic [`EXEC_DATA_W-1:0] immQ, rsQ, rtQ;
    logic [`EXEC_DATA_W-1:0] exMemQ, memWbAluQ, memWbMemQ;
    resKind                  kindQ;
    fwdSel                   fwdSelAQ, fwdSelBQ;

    // Stage outputs
    logic [`EXEC_DATA_W-1:0] stResult;
    logic                    stZero, stLtz, stErr;

    exec_decode decode0 (
        .instr  (instr),
        .op     (decOp),
        .useImm (decUseImm),
        .invA   (decInvA),
        .invB   (decInvB),
        .cIn    (decCIn),
        .ovfEn  (decOvfEn),
        .immVal (decImm),
        .kind   (decKind)
    );

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            validQ <= 1'b0;
        end else begin
            validQ <= inValid;
        end
    end

    // Payload only loads on a strobe
    always_ff @(posedge clk) begin
        if (inValid) begin
            opQ       <= decOp;
            useImmQ   <= decUseImm;
            invAQ     <= decInvA;
            invBQ     <= decInvB;
            cInQ      <= decCIn;
            ovfEnQ    <= decOvfEn;
            immQ      <= decImm;
            kindQ     <= decKind;
            rsQ       <= rsData;
            rtQ       <= rtData;
            exMemQ    <= aluResExMem;
            memWbAluQ <= aluResMemWb;
            memWbMemQ <= memDataMemWb;
            fwdSelAQ  <= fwdSelA;
            fwdSelBQ  <= fwdSelB;
        end
    end

    exec_stage stage0 (
        .rsData       (rsQ),
        .rtData       (rtQ),
        .immVal       (immQ),
        .aluResExMem  (exMemQ),
        .aluResMemWb  (memWbAluQ),
        .memDataMemWb (memWbMemQ),
        .fwdSelA      (fwdSelAQ),
        .fwdSelB      (fwdSelBQ),
        .op           (opQ),
        .useImm       (useImmQ),
        .invA         (invAQ),
        .invB         (invBQ),
        .cIn          (cInQ),
        .ovfEn        (ovfEnQ),
        .kind         (kindQ),
        .result       (stResult),
        .zero         (stZero),
        .ltz          (stLtz),
        .err          (stErr)
    );

    // Outputs hold their last value between strobes
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            outValid <= 1'b0;
            result   <= '0;
            zero     <= 1'b0;
            ltz      <= 1'b0;
            err      <= 1'b0;
        end else begin
            outValid <= validQ;
            if (validQ) begin
                result <= stResult;
                zero   <= stZero;
                ltz    <= stLtz;
                err    <= stErr;
            end
        end
    end

endmodule

//--- run.sh
#!/usr/bin/env bash
# Build the execute stage testbench with Verilator, run it and check the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps --top-module tb_exec -f src.f \
    -o tb_exec_sim > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/tb_exec_sim > sim.log 2>&1
cat sim.log
grep -qx "RESULT: PASS" sim.log && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }

//--- src.f
+incdir+.
exec_pkg.sv
exec_shifter.sv
exec_alu.sv
exec_decode.sv
exec_stage.sv
exec_top.sv
tb_exec.sv

//--- tb_exec.sv
// Testbench for the execute stage
// Replays instruction vectors from a data file and checks every result
// against the expected values when the output strobe appears
`timescale 1ns/1ps
`include "exec_defs.svh"

module tb_exec;
    import exec_pkg::*;

    localparam int NumVec   = 46;
    localparam int Latency  = 2;
    localparam int ResetLen = 10;

    // One line of the vector file, each field padded to whole hex digits
    typedef struct packed {
        instrWord                instr;
        logic [`EXEC_DATA_W-1:0] rsData;
        logic [`EXEC_DATA_W-1:0] rtData;
        logic [1:0]              padA;
        fwdSel                   fwdSelA;
        logic [1:0]              padB;
        fwdSel                   fwdSelB;
        logic [`EXEC_DATA_W-1:0] exMemAlu;
        logic [`EXEC_DATA_W-1:0] memWbAlu;
        logic [`EXEC_DATA_W-1:0] memWbMem;
        logic [7:0]              gap;
        logic [`EXEC_DATA_W-1:0] expResult;
        logic [2:0]              padZ;
        logic                    expZero;
        logic [2:0]              padL;
        logic                    expLtz;
        logic [2:0]              padE;
        logic                    expErr;
    } vecRec;

    logic                    clk = 1'b0;
    logic                    rstN;
    logic                    inValid;
    instrWord                instr;
    logic [`EXEC_DATA_W-1:0] rsData, rtData;
    logic [`EXEC_DATA_W-1:0] aluResExMem, aluResMemWb, memDataMemWb;
    fwdSel                   fwdSelA, fwdSelB;
    logic                    outValid;
    logic [`EXEC_DATA_W-1:0] result;
    logic                    zero, ltz, err;

    vecRec vecs [0:NumVec-1];
    int    expIdx[$];
    int    issueCyc[$];
    int    cycles     = 0;
    int    cycleLimit = 0;

    exec_top dut0 (
        .clk          (clk),
        .rstN         (rstN),
        .inValid      (inValid),
        .instr        (instr),
        .rsData       (rsData),
        .rtData       (rtData),
        .aluResExMem  (aluResExMem),
        .aluResMemWb  (aluResMemWb),
        .memDataMemWb (memDataMemWb),
        .fwdSelA      (fwdSelA),
        .fwdSelB      (fwdSelB),
        .outValid     (outValid),
        .result       (result),
        .zero         (zero),
        .ltz          (ltz),
        .err          (err)
    );

    always #5 clk = ~clk;

    task automatic compareWord(input string name, input logic [`EXEC_DATA_W-1:0] got,
                               input logic [`EXEC_DATA_W-1:0] exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
            $display("RESULT: FAIL");
            $fatal(1, "wrong value on %s", name);
        end
    endtask

    task automatic compareFlag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got %b expected %b", $time, name, got, exp);
            $display("RESULT: FAIL");
            $fatal(1, "wrong value on %s", name);
        end
    endtask

    // Nothing in flight, so the output register must still hold its reset value
    task automatic checkIdle();
        compareFlag("outValid", outValid, 1'b0);
        compareWord("result", result, '0);
        compareFlag("zero", zero, 1'b0);
        compareFlag("ltz", ltz, 1'b0);
        compareFlag("err", err, 1'b0);
    endtask

    task automatic applyVector(input vecRec v);
        instr        = v.instr;
        rsData       = v.rsData;
        rtData       = v.rtData;
        fwdSelA      = v.fwdSelA;
        fwdSelB      = v.fwdSelB;
        aluResExMem  = v.exMemAlu;
        aluResMemWb  = v.memWbAlu;
        memDataMemWb = v.memWbMem;
    endtask

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycleLimit > 0 && cycles >= cycleLimit) begin
            $display("Timeout after %0d cycles, %0d results never arrived",
                     cycles, expIdx.size());
            $display("RESULT: FAIL");
            $fatal(1, "run stopped at the cycle limit");
        end
    end

    // Outputs are sampled on the falling edge, half a cycle after they change
    always @(negedge clk) begin : checkOutputs
        vecRec rec;
        int    idx;
        int    lat;
        if (outValid) begin
            if (expIdx.size() == 0) begin
                $display("outValid was high at %0t with no instruction in flight", $time);
                $display("RESULT: FAIL");
                $fatal(1, "unexpected output strobe");
            end else begin
                idx = expIdx.pop_front();
                lat = cycles - issueCyc.pop_front();
                rec = vecs[idx];
                if (lat != Latency) begin
                    $display("Vector %0d came out %0d cycles after its strobe instead of %0d",
                             idx, lat, Latency);
                    $display("RESULT: FAIL");
                    $fatal(1, "wrong latency");
                end else begin
                    compareWord("result", result, rec.expResult);
                    compareFlag("zero", zero, rec.expZero);
                    compareFlag("ltz", ltz, rec.expLtz);
                    compareFlag("err", err, rec.expErr);
                end
            end
        end
    end

    initial begin
        int gapSum;
        rstN         = 1'b0;
        inValid      = 1'b0;
        instr        = '0;
        rsData       = '0;
        rtData       = '0;
        aluResExMem  = '0;
        aluResMemWb  = '0;
        memDataMemWb = '0;
        fwdSelA      = fwdNone;
        fwdSelB      = fwdNone;

        $readmemh("tb_exec_input.txt", vecs);
        gapSum = 0;
        for (int k = 0; k < NumVec; k++) begin
            gapSum = gapSum + int'(vecs[k].gap);
        end
        cycleLimit = 4 * NumVec + gapSum + 50;

        for (int c = 0; c < ResetLen; c++) begin
            @(negedge clk);
            checkIdle();
        end
        rstN = 1'b1;
        repeat (3) begin
            @(negedge clk);
            checkIdle();
        end

        // A gap of zero puts the next strobe in the very next cycle
        for (int k = 0; k < NumVec; k++) begin
            @(negedge clk);
            applyVector(vecs[k]);
            inValid = 1'b1;
            expIdx.push_back(k);
            issueCyc.push_back(cycles);
            if (vecs[k].gap != 8'd0) begin
                @(negedge clk);
                inValid = 1'b0;
                repeat (int'(vecs[k].gap) - 1) @(negedge clk);
            end
        end
        @(negedge clk);
        inValid = 1'b0;

        while (expIdx.size() != 0) begin
            @(negedge clk);
        end
        // Quiet cycles catch any extra output strobe
        repeat (3) @(negedge clk);
        $display("RESULT: PASS");
        $finish;
    end

endmodule

//--- tb_exec_input.txt
// instr_rs_rt_fwdA_fwdB_exMemAlu_memWbAlu_memWbMem_gap_result_zero_ltz_err, all hex
// fwd 0 register, 1 MEM/WB ALU, 2 EX/MEM ALU, 3 MEM/WB memory; gap is idle cycles after
4143_0005_0000_0_0_1111_2222_3333_01_0008_0_0_0 // ADDI 5 + 3
4141_7FFF_0000_0_0_1111_2222_3333_00_8000_0_1_1 // ADDI overflow
415D_0003_0000_0_0_1111_2222_3333_02_0000_1_0_0 // ADDI 3 + -3
4945_0002_0000_0_0_1111_2222_3333_00_0003_0_0_0 // SUBI 5 - 2
4942_0007_0000_0_0_1111_2222_3333_01_FFFB_0_1_0 // SUBI 2 - 7
4940_8000_0000_0_0_1111_2222_3333_00_8000_0_1_1 // SUBI 0 - min, overflow
515F_00FF_0000_0_0_1111_2222_3333_00_00E0_0_0_0 // XORI zero-extended
5955_801F_0000_0_0_1111_2222_3333_03_800A_0_1_0 // ANDNI zero-extended
D94C_1234_4321_0_0_1111_2222_3333_00_5555_0_0_0 // ADD
D94C_8000_8000_0_0_1111_2222_3333_00_0000_1_0_1 // ADD overflow to zero
D94D_0003_000A_0_0_1111_2222_3333_00_0007_0_0_0 // SUB is rt - rs
D94D_0001_8000_0_0_1111_2222_3333_00_7FFF_0_0_1 // SUB overflow
D94E_F0F0_FF00_0_0_1111_2222_3333_00_0FF0_0_0_0 // XOR
D94F_FFFF_0F0F_0_0_1111_2222_3333_02_F0F0_0_1_0 // ANDN
8141_7FFF_0000_0_0_1111_2222_3333_00_8000_0_1_0 // ST wraps, no err
995F_8000_0000_0_0_1111_2222_3333_01_7FFF_0_0_0 // STU wraps, no err
A140_8123_0000_0_0_1111_2222_3333_00_8123_0_1_0 // ROLI 0
A141_8123_0000_0_0_1111_2222_3333_00_0247_0_0_0 // ROLI 1
A947_8123_0000_0_0_1111_2222_3333_00_9180_0_1_0 // SLLI 7
B148_8123_0000_0_0_1111_2222_3333_00_2381_0_0_0 // RORI 8
B94F_8123_0000_0_0_1111_2222_3333_01_0001_0_0_0 // SRLI 15
D14C_8123_0008_0_0_1111_2222_3333_00_2381_0_0_0 // ROL by rt
D14D_8123_000F_0_0_1111_2222_3333_00_8000_0_1_0 // SLL by rt
D14E_8123_0007_0_0_1111_2222_3333_00_4702_0_0_0 // ROR by rt
D14F_8123_FFF1_0_0_1111_2222_3333_02_4091_0_0_0 // SRL, only rt[3:0] counts
C940_8123_0000_0_0_1111_2222_3333_00_C481_0_1_0 // BTR
C180_5A5A_0000_0_0_1111_2222_3333_00_FF80_0_1_0 // LBI negative byte
91CD_12AB_0000_0_0_1111_2222_3333_01_ABCD_0_1_0 // SLBI
E14C_1234_1234_0_0_1111_2222_3333_00_0001_1_0_0 // SEQ equal
E14C_1234_1235_0_0_1111_2222_3333_00_0000_0_0_0 // SEQ not equal
E94C_8000_7FFF_0_0_1111_2222_3333_00_0001_0_1_0 // SLT, difference overflows
F14C_0005_0005_0_0_1111_2222_3333_00_0001_1_0_0 // SLE equal
F14C_7FFF_8000_0_0_1111_2222_3333_00_0000_0_0_0 // SLE, difference overflows
F94C_FFFF_0001_0_0_1111_2222_3333_00_0001_1_0_0 // SCO carry
F94C_7FFF_0001_0_0_1111_2222_3333_03_0000_0_1_0 // SCO no carry
61A5_0000_0000_0_0_1111_2222_3333_00_0000_1_0_0 // BEQZ
6912_0042_0000_0_0_1111_2222_3333_00_0042_0_0_0 // BNEZ
71F0_FF00_0000_0_0_1111_2222_3333_00_FF00_0_1_0 // BLTZ
7903_7FFF_0000_0_0_1111_2222_3333_01_7FFF_0_0_0 // BGEZ
D94C_DEAD_0010_1_0_1111_0100_3333_00_0110_0_0_0 // rs from MEM/WB ALU
D94C_DEAD_0010_2_0_0200_2222_3333_00_0210_0_0_0 // rs from EX/MEM ALU
D94C_DEAD_0010_3_0_1111_2222_0300_00_0310_0_0_0 // rs from MEM/WB memory
D94C_0001_BEEF_0_1_1111_1000_3333_00_1001_0_0_0 // rt from MEM/WB ALU
D94C_0001_BEEF_0_2_2000_2222_3333_00_2001_0_0_0 // rt from EX/MEM ALU
D94C_0001_BEEF_0_3_1111_2222_3000_00_3001_0_0_0 // rt from MEM/WB memory
D94D_DEAD_BEEF_2_3_0005_2222_0003_00_FFFE_0_1_0 // SUB, both forwarded
